//--- common/bec_ctrl_pkg.sv
// **************************************
// Shared widths, command codes and types
// for the Edwards curve accelerator host
// controller. Every RTL module imports it
// by wildcard in its header.
// **************************************
`default_nettype none

package bec_ctrl_pkg;

	// Field element width
	localparam int OPERAND_BITS = 163;
	// Bus and probe width
	localparam int WORD_BITS = 32;
	localparam int WORDS_PER_OPERAND = 6;
	localparam int NUM_OPERANDS = 6;
	localparam int STREAM_WORDS = 36;
	// w_out words first, then z_out
	localparam int RESULT_WORDS = 12;
	// Operand zero-extended to whole bus words
	localparam int OPERAND_EXT_BITS = WORD_BITS * WORDS_PER_OPERAND;
	// Payload width of a readback chunk
	localparam int CHUNK_BITS = 28;
	// Payload width of a write command
	localparam int PAYLOAD_BITS = 26;
	localparam int IDX_BITS = 6;
	// Run-cycle count field, wide enough for any CNT_BITS in use
	localparam int RUN_CNT_BITS = 24;

	// Begin a job, upper half
	localparam logic [15:0] CMD_BEGIN = 16'hAB30;
	// Commit buffers and start, upper half
	localparam logic [15:0] CMD_START = 16'hEF41;
	// End the job, full word
	localparam logic [31:0] CMD_DONE = 32'hAB500000;

	localparam logic [31:0] BUSY_WORD = 32'hBC000000;
	localparam logic [31:0] STATUS_BASE = 32'hC8000000;
	localparam int KEY_SLOT = 6;

	// Job phases, stepped in this order and back to idle after read
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_LOAD,
		PH_STREAM,
		PH_RUN,
		PH_COLLECT,
		PH_READ
	} phase_t;

	typedef struct packed {
		phase_t phase;
		logic [IDX_BITS-1:0] idx;
		logic commit;
		logic [RUN_CNT_BITS-1:0] run_cnt;
	} step_t;

	typedef struct packed {
		logic [OPERAND_BITS-1:0] w_out;
		logic [OPERAND_BITS-1:0] z_out;
	} result_t;

	// Operand write during load
	typedef struct packed {
		logic [2:0] slot;
		logic [2:0] chunk;
		logic [PAYLOAD_BITS-1:0] payload;
	} probe_wr_t;

	// Control command or read request
	typedef struct packed {
		logic [15:0] opcode;
		logic [15:0] arg;
	} probe_cmd_t;

	typedef union packed {
		probe_wr_t wr;
		probe_cmd_t cmd;
	} probe_word_t;

endpackage

`default_nettype wire

//--- rtl/phase_sequencer.sv
// **************************************
// Job phase FSM. Decodes the control
// commands and broadcasts phase, word
// index, commit pulse and run count.
// **************************************
`default_nettype none

module phase_sequencer import bec_ctrl_pkg::*; #(
	parameter int CNT_BITS = 18
) (
	input logic clk,
	input logic rst,
	input probe_word_t la_data_in,
	input logic slv_done,
	output step_t step
);

	phase_t phase;
	logic [IDX_BITS-1:0] idx;
	logic [CNT_BITS-1:0] run_cnt;
	logic commit;

	// Start seen in load, buffers are copied on this same edge
	assign commit = (phase == PH_LOAD) && (la_data_in.cmd.opcode == CMD_START);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= PH_IDLE;
			idx <= '0;
			run_cnt <= '0;
		end else begin
			case (phase)
				PH_IDLE: begin
					if (la_data_in.cmd.opcode == CMD_BEGIN)
						phase <= PH_LOAD;
				end
				PH_LOAD: begin
					if (commit) begin
						phase <= PH_STREAM;
						idx <= '0;
						run_cnt <= '0;
					end
				end
				PH_STREAM: begin
					if (idx == IDX_BITS'(STREAM_WORDS - 1)) begin
						phase <= PH_RUN;
						idx <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				PH_RUN: begin
					// The cycle that samples done still counts
					run_cnt <= run_cnt + 1'b1;
					if (slv_done) begin
						phase <= PH_COLLECT;
						idx <= '0;
					end
				end
				PH_COLLECT: begin
					if (idx == IDX_BITS'(RESULT_WORDS - 1)) begin
						phase <= PH_READ;
						idx <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				PH_READ: begin
					if (la_data_in == CMD_DONE)
						phase <= PH_IDLE;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	assign step.phase = phase;
	assign step.idx = idx;
	assign step.commit = commit;
	assign step.run_cnt = RUN_CNT_BITS'(run_cnt);

endmodule

`default_nettype wire

//--- operand_path/operand_bank.sv
// **************************************
// Staging and committed operand storage.
// Writes land in load, the start command
// commits them, then they stream out as
// bus words and the key shifts out by bit.
// **************************************
`default_nettype none

module operand_bank import bec_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input step_t step,
	input probe_word_t la_data_in,
	input logic next_key,
	output logic load_data,
	output logic slv_enable,
	output logic ki,
	output logic [WORD_BITS-1:0] data_out
);

	// Six operands plus the key
	localparam int SLOTS = NUM_OPERANDS + 1;
	// Bits left below the last full payload chunk
	localparam int TAIL_BITS = OPERAND_BITS - WORDS_PER_OPERAND * PAYLOAD_BITS;

	logic [OPERAND_BITS-1:0] stage [SLOTS];
	logic [OPERAND_BITS-1:0] opnd [SLOTS];
	logic [2:0] wr_slot;
	logic [2:0] wr_chunk;
	logic [PAYLOAD_BITS-1:0] wr_data;
	logic wr_en;
	logic [2:0] op_sel;
	logic [2:0] word_sel;
	logic [OPERAND_EXT_BITS-1:0] op_ext;

	assign wr_slot = la_data_in.wr.slot;
	assign wr_chunk = la_data_in.wr.chunk;
	assign wr_data = la_data_in.wr.payload;
	// Slot 7 is never a buffer, so command words fall through here
	assign wr_en = (step.phase == PH_LOAD) && (wr_slot <= 3'(KEY_SLOT));

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SLOTS; i++)
				stage[i] <= '0;
		end else if (wr_en) begin
			if (wr_chunk < 3'(WORDS_PER_OPERAND)) begin
				// Chunk 0 holds the most significant payload
				stage[wr_slot][OPERAND_BITS-1-PAYLOAD_BITS*wr_chunk -: PAYLOAD_BITS] <= wr_data;
			end else if (wr_chunk == 3'(WORDS_PER_OPERAND)) begin
				stage[wr_slot][TAIL_BITS-1:0] <= wr_data[TAIL_BITS-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < SLOTS; i++)
				opnd[i] <= '0;
		end else if (step.commit) begin
			for (int i = 0; i < SLOTS; i++)
				opnd[i] <= stage[i];
		end else if ((step.phase == PH_RUN) && next_key) begin
			// Rotate right, the next key bit shows at bit 0
			opnd[KEY_SLOT] <= {opnd[KEY_SLOT][0], opnd[KEY_SLOT][OPERAND_BITS-1:1]};
		end
	end

	// Operand k/6, word k%6, least significant word first
	assign op_sel = 3'(step.idx / WORDS_PER_OPERAND);
	assign word_sel = 3'(step.idx % WORDS_PER_OPERAND);
	assign op_ext = OPERAND_EXT_BITS'(opnd[op_sel]);

	assign load_data = (step.phase == PH_STREAM);
	assign data_out = load_data ? op_ext[word_sel*WORD_BITS +: WORD_BITS] : '0;

	assign slv_enable = (step.phase == PH_RUN);
	assign ki = slv_enable & opnd[KEY_SLOT][0];

endmodule

`default_nettype wire

//--- result_path/result_capture.sv
// **************************************
// Captures w_out and z_out from the
// accelerator bus during collect and
// holds them for readback.
// **************************************
`default_nettype none

module result_capture import bec_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input step_t step,
	input logic [WORD_BITS-1:0] data_in,
	output result_t results
);

	logic [WORD_BITS-1:0] words [RESULT_WORDS];
	logic [OPERAND_EXT_BITS-1:0] w_ext;
	logic [OPERAND_EXT_BITS-1:0] z_ext;
	logic cap_en;

	assign cap_en = (step.phase == PH_COLLECT) && (step.idx < IDX_BITS'(RESULT_WORDS));

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < RESULT_WORDS; i++)
				words[i] <= '0;
		end else if (cap_en) begin
			words[step.idx[3:0]] <= data_in;
		end
	end

	// First six words are w_out, the rest z_out, low word first
	always_comb begin
		for (int i = 0; i < WORDS_PER_OPERAND; i++) begin
			w_ext[i*WORD_BITS +: WORD_BITS] = words[i];
			z_ext[i*WORD_BITS +: WORD_BITS] = words[i+WORDS_PER_OPERAND];
		end
	end

	assign results.w_out = w_ext[OPERAND_BITS-1:0];
	assign results.z_out = z_ext[OPERAND_BITS-1:0];

endmodule

`default_nettype wire

//--- rtl/status_readback.sv
// **************************************
// Registered probe output. Shows busy
// while a job runs, tagged result chunks
// on read requests and the final status.
// **************************************
`default_nettype none

module status_readback import bec_ctrl_pkg::*; #(
	parameter int CNT_BITS = 18
) (
	input logic clk,
	input logic rst,
	input step_t step,
	input probe_word_t la_data_in,
	input result_t results,
	output logic [WORD_BITS-1:0] la_data_out
);

	// Chunks per result and the padded result width
	localparam int CHUNKS = RESULT_WORDS / 2;
	localparam int PAD_BITS = CHUNK_BITS * CHUNKS;

	logic [PAD_BITS-1:0] w_pad;
	logic [PAD_BITS-1:0] z_pad;
	logic [3:0] req;
	logic [2:0] pos;
	logic is_req;
	logic [CHUNK_BITS-1:0] chunk;
	logic [WORD_BITS-1:0] status;

	// Read request is 0x000N0000
	assign req = la_data_in.cmd.opcode[3:0];
	assign is_req = (la_data_in.cmd.opcode[15:4] == '0) && (la_data_in.cmd.arg == '0)
		&& (req < 4'(RESULT_WORDS));

	assign w_pad = PAD_BITS'(results.w_out);
	assign z_pad = PAD_BITS'(results.z_out);
	assign pos = (req < 4'(CHUNKS)) ? req[2:0] : 3'(req - 4'(CHUNKS));
	assign chunk = (req < 4'(CHUNKS)) ? w_pad[PAD_BITS-1-CHUNK_BITS*pos -: CHUNK_BITS]
		: z_pad[PAD_BITS-1-CHUNK_BITS*pos -: CHUNK_BITS];

	assign status = STATUS_BASE ^ WORD_BITS'(step.run_cnt[CNT_BITS-1:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			la_data_out <= '0;
		end else begin
			case (step.phase)
				PH_STREAM, PH_RUN, PH_COLLECT: la_data_out <= BUSY_WORD;
				PH_READ: begin
					// Other words leave the last answer in place
					if (la_data_in == CMD_DONE)
						la_data_out <= status;
					else if (is_req)
						la_data_out <= {req + 4'd1, chunk};
				end
				default: la_data_out <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/bec_controller.sv
// **************************************
// Top level of the accelerator host
// controller. Connects the probe words to
// the accelerator bus, one job at a time.
// **************************************
`default_nettype none

module bec_controller import bec_ctrl_pkg::*; #(
	parameter int CNT_BITS = 18
) (
	input logic clk,
	input logic rst,
	input probe_word_t la_data_in,
	input logic next_key,
	input logic slv_done,
	input logic [WORD_BITS-1:0] data_in,
	output logic [WORD_BITS-1:0] la_data_out,
	output logic load_data,
	output logic slv_enable,
	output logic [WORD_BITS-1:0] data_out,
	output logic ki
);

	step_t step;
	result_t results;

	phase_sequencer #(
		.CNT_BITS(CNT_BITS)
	) u_sequencer (
		.clk(clk),
		.rst(rst),
		.la_data_in(la_data_in),
		.slv_done(slv_done),
		.step(step)
	);

	// Operands and key toward the accelerator
	operand_bank u_operand_bank (
		.clk(clk),
		.rst(rst),
		.step(step),
		.la_data_in(la_data_in),
		.next_key(next_key),
		.load_data(load_data),
		.slv_enable(slv_enable),
		.ki(ki),
		.data_out(data_out)
	);

	// Results back from the accelerator
	result_capture u_result_capture (
		.clk(clk),
		.rst(rst),
		.step(step),
		.data_in(data_in),
		.results(results)
	);

	status_readback #(
		.CNT_BITS(CNT_BITS)
	) u_status_readback (
		.clk(clk),
		.rst(rst),
		.step(step),
		.la_data_in(la_data_in),
		.results(results),
		.la_data_out(la_data_out)
	);

endmodule

`default_nettype wire

//--- testbench/tb_bec_controller.sv
// ****************************************
// Testbench for the accelerator host
// controller. Runs random jobs with an
// accelerator model and a reference model
// and reports per-test counts.
// ****************************************
`default_nettype none

module tb_bec_controller import bec_ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_JOBS = 3;
	localparam int IDLE_WORDS = 4;
	localparam int RUN_MAX = 40;
	localparam int LOAD_WRITES = 7 * 7;
	localparam int JOB_CYCLES = IDLE_WORDS + LOAD_WRITES + 2 + STREAM_WORDS + RUN_MAX
		+ RESULT_WORDS + 4 * RESULT_WORDS + 6;
	localparam int TIMEOUT_NS = (2 * NUM_JOBS * JOB_CYCLES + 20) * CLK_PERIOD;

	localparam int T_RESET = 0;
	localparam int T_STREAM = 1;
	localparam int T_KEY = 2;
	localparam int T_READ = 3;
	localparam int T_DONE = 4;

	logic clk = 1'b0;
	logic rst;
	probe_word_t la_data_in;
	logic next_key;
	logic slv_done;
	logic [WORD_BITS-1:0] data_in;
	logic [WORD_BITS-1:0] la_data_out;
	logic load_data;
	logic slv_enable;
	logic [WORD_BITS-1:0] data_out;
	logic ki;

	logic [31:0] seed = 32'd90525;
	int checks[5];
	int errs[5];
	string names[5] = '{"reset", "operand load and stream", "key serialisation",
		"busy and result readback", "done status"};

	// Reference model state
	logic [OPERAND_BITS-1:0] m_stage [7];
	logic [OPERAND_BITS-1:0] m_op [7];
	logic [OPERAND_BITS-1:0] m_key;
	logic [WORD_BITS-1:0] rword [RESULT_WORDS];

	bec_controller #(
		.CNT_BITS(18)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.la_data_in(la_data_in),
		.next_key(next_key),
		.slv_done(slv_done),
		.data_in(data_in),
		.la_data_out(la_data_out),
		.load_data(load_data),
		.slv_enable(slv_enable),
		.data_out(data_out),
		.ki(ki)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] rand_word();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic check(input int t, input bit ok, input string msg);
		checks[t]++;
		assert (ok) else begin
			errs[t]++;
			$display("Fail at %0d ns: %s", $time, msg);
		end
	endtask

	// Chunk 0 is the top 26 bits, chunk 6 the low 7 bits
	function automatic void stage_write(input int slot, input int chunk,
		input logic [25:0] payload);
		if (chunk < 6) begin
			for (int b = 0; b < 26; b++)
				m_stage[slot][137 - 26 * chunk + b] = payload[b];
		end else begin
			for (int b = 0; b < 7; b++)
				m_stage[slot][b] = payload[b];
		end
	endfunction

	function automatic logic [31:0] stream_word(input int k);
		logic [31:0] w;
		int pos;
		w = '0;
		for (int b = 0; b < 32; b++) begin
			pos = 32 * (k % 6) + b;
			if (pos < OPERAND_BITS)
				w[b] = m_op[k / 6][pos];
		end
		return w;
	endfunction

	// Result zero-extended to 168 bits with chunk 0 at the top
	function automatic logic [27:0] result_chunk(input int n);
		logic [167:0] ext;
		int wi;
		ext = '0;
		for (int b = 0; b < OPERAND_BITS; b++) begin
			wi = (n < 6) ? b / 32 : 6 + b / 32;
			ext[b] = rword[wi][b % 32];
		end
		return ext[167 - 28 * (n % 6) -: 28];
	endfunction

	task automatic drive_probe(input logic [31:0] w);
		@(posedge clk);
		la_data_in <= w;
		@(negedge clk);
	endtask

	task automatic load_operands();
		int order[LOAD_WRITES];
		int j;
		int tmp;
		logic [31:0] w;
		// Idle writes must leave the buffers alone
		for (int i = 0; i < IDLE_WORDS; i++) begin
			w = rand_word();
			w[31:29] = 3'(rand_word() % 7);
			if (w[31:16] == CMD_BEGIN)
				w[16] = ~w[16];
			drive_probe(w);
			check(T_READ, la_data_out == '0, "probe output not zero in idle");
		end
		w = rand_word();
		drive_probe({CMD_BEGIN, w[15:0]});
		for (int i = 0; i < LOAD_WRITES; i++)
			order[i] = i;
		for (int i = LOAD_WRITES - 1; i > 0; i--) begin
			j = rand_word() % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		// Some chunks are skipped and keep the previous job's value
		for (int i = 0; i < LOAD_WRITES; i++) begin
			if (rand_word() % 4 != 0) begin
				w = rand_word();
				w[31:29] = 3'(order[i] / 7);
				w[28:26] = 3'(order[i] % 7);
				stage_write(order[i] / 7, order[i] % 7, w[25:0]);
				drive_probe(w);
				check(T_READ, la_data_out == '0, "probe output not zero in load");
			end
		end
		w = rand_word();
		drive_probe({CMD_START, w[15:0]});
		for (int s = 0; s < 7; s++)
			m_op[s] = m_stage[s];
		m_key = m_op[KEY_SLOT];
	endtask

	// Accelerator model for stream, run and collect
	task automatic accel_job(output int run_seen);
		int run_len;
		int streamed;
		int next_col;
		int cur_col;
		bit busy_prev;
		bit finished;
		bit done_next;
		logic [31:0] r;
		run_len = 2 + rand_word() % (RUN_MAX - 1);
		for (int i = 0; i < RESULT_WORDS; i++)
			rword[i] = rand_word();
		run_seen = 0;
		streamed = 0;
		next_col = -1;
		busy_prev = 1'b0;
		finished = 1'b0;
		done_next = 1'b0;
		while (!finished) begin
			@(posedge clk);
			r = rand_word();
			next_key <= r[0];
			slv_done <= done_next;
			data_in <= (next_col >= 0) ? rword[next_col] : rand_word();
			cur_col = next_col;
			@(negedge clk);
			if (busy_prev)
				check(T_READ, la_data_out == BUSY_WORD, "probe output not busy");
			if (load_data) begin
				check(T_STREAM, (streamed < STREAM_WORDS)
					&& (data_out == stream_word(streamed)), "streamed word mismatch");
				streamed++;
			end
			if (slv_enable) begin
				run_seen++;
				check(T_KEY, ki == m_key[0], "key bit mismatch");
				if (next_key)
					m_key = {m_key[0], m_key[OPERAND_BITS-1:1]};
			end else begin
				check(T_KEY, ki == 1'b0, "key bit high outside run");
			end
			busy_prev = load_data || slv_enable || (cur_col >= 0);
			done_next = slv_enable && (run_seen == run_len - 1);
			if (slv_enable && slv_done) begin
				next_col = 0;
			end else if (cur_col >= 0 && cur_col < RESULT_WORDS - 1) begin
				next_col = cur_col + 1;
			end else begin
				next_col = -1;
				finished = (cur_col == RESULT_WORDS - 1);
			end
		end
		check(T_STREAM, streamed == STREAM_WORDS, "wrong number of load_data cycles");
		check(T_DONE, run_seen == run_len, "wrong number of slv_enable cycles");
	endtask

	task automatic read_back(input int run_seen);
		int order[RESULT_WORDS];
		int j;
		int tmp;
		logic [31:0] w;
		logic [31:0] expected;
		for (int i = 0; i < RESULT_WORDS; i++)
			order[i] = i;
		for (int i = RESULT_WORDS - 1; i > 0; i--) begin
			j = rand_word() % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < RESULT_WORDS; i++) begin
			drive_probe({12'h000, 4'(order[i]), 16'h0000});
			if (i == 0)
				check(T_READ, la_data_out == BUSY_WORD, "busy missing after collect");
			@(posedge clk);
			@(negedge clk);
			expected = {4'(order[i] + 1), result_chunk(order[i])};
			check(T_READ, la_data_out == expected, "result chunk mismatch");
			// Unrelated word must hold the last answer
			if (rand_word() % 3 == 0) begin
				w = rand_word();
				drive_probe({4'h7, w[27:0]});
				@(posedge clk);
				@(negedge clk);
				check(T_READ, la_data_out == expected, "readback not held");
			end
		end
		drive_probe(CMD_DONE);
		@(posedge clk);
		@(negedge clk);
		check(T_DONE, la_data_out == (STATUS_BASE ^ 32'(run_seen)), "status word mismatch");
		@(posedge clk);
		@(negedge clk);
		check(T_DONE, la_data_out == '0, "probe output not zero after done");
	endtask

	initial begin
		int run_seen;
		int total_checks;
		int total_errs;
		rst = 1'b1;
		la_data_in = '0;
		next_key = 1'b0;
		slv_done = 1'b0;
		data_in = '0;
		for (int s = 0; s < 7; s++)
			m_stage[s] = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check(T_RESET, la_data_out == '0, "la_data_out not zero after reset");
		check(T_RESET, !load_data && !slv_enable && !ki, "strobes high after reset");
		check(T_RESET, data_out == '0, "data_out not zero after reset");
		$display("Test 1 %s: %0d checks, %0d errors", names[T_RESET],
			checks[T_RESET], errs[T_RESET]);

		for (int job = 0; job < NUM_JOBS; job++) begin
			load_operands();
			accel_job(run_seen);
			read_back(run_seen);
		end

		total_checks = 0;
		total_errs = 0;
		for (int t = 0; t < 5; t++) begin
			if (t > T_RESET)
				$display("Test %0d %s: %0d checks, %0d errors", t + 1, names[t],
					checks[t], errs[t]);
			total_checks += checks[t];
			total_errs += errs[t];
		end
		$display("Jobs %0d, checks %0d, errors %0d", NUM_JOBS, total_checks, total_errs);
		if (total_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
common/bec_ctrl_pkg.sv
rtl/phase_sequencer.sv
operand_path/operand_bank.sv
result_path/result_capture.sv
rtl/status_readback.sv
rtl/bec_controller.sv
testbench/tb_bec_controller.sv

//--- Bender.yml
package:
  name: bec_controller

sources:
  - files:
      - common/bec_ctrl_pkg.sv
      - rtl/phase_sequencer.sv
      - operand_path/operand_bank.sv
      - result_path/result_capture.sv
      - rtl/status_readback.sv
      - rtl/bec_controller.sv
  - target: test
    files:
      - testbench/tb_bec_controller.sv
